// File: list.f
common/axi_cfg_pkg.sv
common/hawk_pkg.sv
stall_wr/pending_rsp_counter.sv
stall_wr/hawk_cpu_stall_wr.sv
hawk/page_map_table.sv
hawk/hawk_lookup_ctrl.sv
design/hacd_wr_top.sv
tests/hacd_wr_tb.sv

// File: Makefile
# Verilator build and run of the write-path translation testbench

SRCS := $(shell grep -v '^+' list.f)

.PHONY: all run clean

all: run

obj_dir/Vhacd_wr_tb: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module hacd_wr_tb \
		-f list.f -Mdir obj_dir -o Vhacd_wr_tb

run: obj_dir/Vhacd_wr_tb
	@out="$$(./obj_dir/Vhacd_wr_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: tests/hacd_wr_tb.sv
/* Directed testbench for the write-path top. The memory-side model accepts every
   AW and W at once and returns OKAY per AW, in order, only while b_release is high. */
`timescale 1ns/10ps

module hacd_wr_tb;
   import axi_cfg_pkg::*;
   import hawk_pkg::*;

   localparam int ADDR_WIDTH      = 32;
   localparam int DATA_WIDTH      = 32;
   localparam int ID_WIDTH        = 4;
   localparam int MAP_ENTRIES     = 8;
   localparam int MAX_PENDING     = 4;
   localparam int PAGE_BITS       = ADDR_WIDTH - PAGE_OFFSET_BITS;
   localparam int STRB_WIDTH      = DATA_WIDTH / 8;
   localparam int IDX_W           = $clog2(MAP_ENTRIES);
   localparam int CLK_PERIOD      = 100;
   localparam int DRIVE_DELAY     = 5;
   localparam int RESET_CYCLES    = 10;
   // Roughly ten times the combined length of all tests
   localparam int WATCHDOG_CYCLES = 2000;
   localparam int AW_W            = ID_WIDTH + ADDR_WIDTH + AXI_LEN_W + AXI_SIZE_W + 2;

   logic clk, rst, hawk_inactive, b_release, release_q;
   logic [ID_WIDTH-1:0] s_awid, m_awid, s_bid, m_bid;
   logic [ADDR_WIDTH-1:0] s_awaddr, m_awaddr;
   logic [AXI_LEN_W-1:0] s_awlen, m_awlen;
   logic [AXI_SIZE_W-1:0] s_awsize, m_awsize;
   burst_t s_awburst, m_awburst;
   logic s_awvalid, s_awready, m_awvalid, m_awready;
   logic [DATA_WIDTH-1:0] s_wdata, m_wdata;
   logic [STRB_WIDTH-1:0] s_wstrb, m_wstrb;
   logic s_wlast, s_wvalid, s_wready, m_wlast, m_wvalid, m_wready;
   resp_t s_bresp, m_bresp;
   logic s_bvalid, s_bready, m_bvalid, m_bready;
   map_cmd_t cfg_cmd;
   logic [IDX_W-1:0] cfg_index;
   logic [PAGE_BITS-1:0] cfg_hppa, cfg_ppa, mapped_hppa;

   // Reference page map as software programmed it
   logic map_valid [MAP_ENTRIES];
   logic [PAGE_BITS-1:0] map_tag [MAP_ENTRIES];
   logic [PAGE_BITS-1:0] map_phys [MAP_ENTRIES];

   // Packed as {id, addr, len, size, burst}, {data, strb, last} and {id, resp}
   logic [AW_W-1:0] exp_aw[$], aw_seen[$];
   logic [DATA_WIDTH+STRB_WIDTH:0] exp_w[$], w_seen[$];
   logic [ID_WIDTH+1:0] exp_b[$], b_seen[$];
   logic [ID_WIDTH-1:0] slave_bq[$];
   logic [31:0] lfsr;
   int aw_count;

   hacd_wr_top #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH),
      .MAP_ENTRIES(MAP_ENTRIES), .MAX_PENDING(MAX_PENDING)) hacd_wr_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_on_error("Timeout, the tests did not complete within the cycle limit");
   end

   // Handshakes are sampled mid-cycle and complete on the next rising edge
   always @(negedge clk) begin
      if (!rst) begin
         if (m_awvalid && m_awready) begin
            aw_seen.push_back({m_awid, m_awaddr, m_awlen, m_awsize, m_awburst});
            slave_bq.push_back(m_awid);
            aw_count++;
         end
         if (m_wvalid && m_wready) w_seen.push_back({m_wdata, m_wstrb, m_wlast});
         if (m_bvalid && m_bready) void'(slave_bq.pop_front());
         if (s_bvalid && s_bready) b_seen.push_back({s_bid, s_bresp});
      end
   end

   // Memory-side B driver samples the release level at the edge
   always @(posedge clk) begin
      release_q = b_release;
      #DRIVE_DELAY;
      m_bvalid = release_q && (slave_bq.size() > 0);
      if (slave_bq.size() > 0) m_bid = slave_bq[0];
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
      else stop_on_error($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   // First valid entry in index order wins and a miss keeps the host page
   function automatic logic [ADDR_WIDTH-1:0] expected_addr(input logic [ADDR_WIDTH-1:0] a);
      logic [ADDR_WIDTH-1:0] r;
      logic found;
      r = a;
      found = 1'b0;
      for (int i = 0; i < MAP_ENTRIES; i++) begin
         if (!hawk_inactive && !found && map_valid[i]
             && (map_tag[i] == a[ADDR_WIDTH-1:PAGE_OFFSET_BITS])) begin
            r[ADDR_WIDTH-1:PAGE_OFFSET_BITS] = map_phys[i];
            found = 1'b1;
         end
      end
      return r;
   endfunction

   task automatic step();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic map_write(input int idx, input logic [PAGE_BITS-1:0] hppa,
                            input logic [PAGE_BITS-1:0] ppa);
      cfg_cmd = MAP_WRITE;
      cfg_index = IDX_W'(idx);
      cfg_hppa = hppa;
      cfg_ppa = ppa;
      step();
      cfg_cmd = MAP_NOP;
      map_valid[idx] = 1'b1;
      map_tag[idx] = hppa;
      map_phys[idx] = ppa;
   endtask

   task automatic map_clear();
      cfg_cmd = MAP_CLEAR;
      step();
      cfg_cmd = MAP_NOP;
      for (int i = 0; i < MAP_ENTRIES; i++) map_valid[i] = 1'b0;
   endtask

   task automatic send_write(input logic [ID_WIDTH-1:0] id,
                             input logic [ADDR_WIDTH-1:0] addr, input int beats);
      logic [DATA_WIDTH-1:0] d;
      exp_aw.push_back({id, expected_addr(addr), AXI_LEN_W'(beats - 1), AXI_SIZE_W'(2),
                        BURST_INCR});
      exp_b.push_back({id, RESP_OKAY});
      s_awid = id;
      s_awaddr = addr;
      s_awlen = AXI_LEN_W'(beats - 1);
      s_awsize = AXI_SIZE_W'(2);
      s_awburst = BURST_INCR;
      s_awvalid = 1'b1;
      @(negedge clk);
      while (!s_awready) @(negedge clk);
      step();
      s_awvalid = 1'b0;
      for (int i = 0; i < beats; i++) begin
         d = rand_bits(DATA_WIDTH);
         exp_w.push_back({d, {STRB_WIDTH{1'b1}}, i == beats - 1});
         s_wdata = d;
         s_wstrb = '1;
         s_wlast = (i == beats - 1);
         s_wvalid = 1'b1;
         @(negedge clk);
         while (!s_wready) @(negedge clk);
         step();
      end
      s_wvalid = 1'b0;
      s_wlast = 1'b0;
   endtask

   // Drains every expected AW, W beat and B response in order
   task automatic drain_and_compare();
      logic [ID_WIDTH-1:0] gid, eid;
      logic [ADDR_WIDTH-1:0] gaddr, eaddr;
      logic [AXI_LEN_W-1:0] glen, elen;
      logic [AXI_SIZE_W-1:0] gsize, esize;
      logic [1:0] gburst, eburst, gresp, eresp;
      logic [DATA_WIDTH+STRB_WIDTH:0] gw, ew;
      while (exp_aw.size() > 0) begin
         while (aw_seen.size() == 0) step();
         {gid, gaddr, glen, gsize, gburst} = aw_seen.pop_front();
         {eid, eaddr, elen, esize, eburst} = exp_aw.pop_front();
         check_value("m_awid", 64'(gid), 64'(eid));
         check_value("m_awaddr", 64'(gaddr), 64'(eaddr));
         check_value("m_awlen", 64'(glen), 64'(elen));
         check_value("m_awsize", 64'(gsize), 64'(esize));
         check_value("m_awburst", 64'(gburst), 64'(eburst));
      end
      while (exp_w.size() > 0) begin
         while (w_seen.size() == 0) step();
         gw = w_seen.pop_front();
         ew = exp_w.pop_front();
         check_value("m_wdata, m_wstrb, m_wlast", 64'(gw), 64'(ew));
      end
      while (exp_b.size() > 0) begin
         while (b_seen.size() == 0) step();
         {gid, gresp} = b_seen.pop_front();
         {eid, eresp} = exp_b.pop_front();
         check_value("s_bid", 64'(gid), 64'(eid));
         check_value("s_bresp", 64'(gresp), 64'(eresp));
      end
   endtask

   task automatic reset_state();
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_value("m_awvalid", 64'(m_awvalid), 64'(0));
         check_value("s_bvalid", 64'(s_bvalid), 64'(0));
      end
      step();
      rst = 1'b0;
      @(negedge clk);
      check_value("m_awvalid", 64'(m_awvalid), 64'(0));
      check_value("s_bvalid", 64'(s_bvalid), 64'(0));
      @(negedge clk);
      check_value("s_awready", 64'(s_awready), 64'(1));
      step();
   endtask

   task automatic translation_hit();
      logic [PAGE_BITS-1:0] ppa;
      mapped_hppa = PAGE_BITS'(rand_bits(PAGE_BITS));
      ppa = PAGE_BITS'(rand_bits(PAGE_BITS));
      if (ppa == mapped_hppa) ppa = ~ppa;
      map_write(2, mapped_hppa, ppa);
      send_write(ID_WIDTH'(rand_bits(ID_WIDTH)),
                 {mapped_hppa, PAGE_OFFSET_BITS'(rand_bits(PAGE_OFFSET_BITS))}, 2);
      drain_and_compare();
   endtask

   task automatic miss_and_clear();
      logic [PAGE_BITS-1:0] page;
      page = PAGE_BITS'(rand_bits(PAGE_BITS));
      if (page == mapped_hppa) page = ~page;
      send_write(ID_WIDTH'(rand_bits(ID_WIDTH)),
                 {page, PAGE_OFFSET_BITS'(rand_bits(PAGE_OFFSET_BITS))}, 1);
      drain_and_compare();
      map_clear();
      send_write(ID_WIDTH'(rand_bits(ID_WIDTH)),
                 {mapped_hppa, PAGE_OFFSET_BITS'(rand_bits(PAGE_OFFSET_BITS))}, 1);
      drain_and_compare();
   endtask

   task automatic bypass_inactive();
      map_write(5, mapped_hppa, ~mapped_hppa);
      hawk_inactive = 1'b1;
      send_write(ID_WIDTH'(rand_bits(ID_WIDTH)),
                 {mapped_hppa, PAGE_OFFSET_BITS'(rand_bits(PAGE_OFFSET_BITS))}, 1);
      drain_and_compare();
      hawk_inactive = 1'b0;
   endtask

   // The write past the cap must go out after a single released B
   task automatic pending_cap();
      int start;
      start = aw_count;
      b_release = 1'b0;
      for (int i = 0; i <= MAX_PENDING; i++) begin
         send_write(ID_WIDTH'(i + 1), ADDR_WIDTH'(rand_bits(ADDR_WIDTH)), 1);
      end
      repeat (50) step();
      check_value("forwarded AW count", 64'(aw_count - start), 64'(MAX_PENDING));
      // Release level held for one edge lets only the oldest B through
      b_release = 1'b1;
      step();
      b_release = 1'b0;
      while (aw_count - start < MAX_PENDING + 1) step();
      b_release = 1'b1;
      drain_and_compare();
   endtask

   initial begin
      lfsr = 32'h3e4c18f6;
      aw_count = 0;
      rst = 1'b1;
      hawk_inactive = 1'b0;
      b_release = 1'b1;
      s_awid = '0;
      s_awaddr = '0;
      s_awlen = '0;
      s_awsize = '0;
      s_awburst = BURST_FIXED;
      s_awvalid = 1'b0;
      s_wdata = '0;
      s_wstrb = '0;
      s_wlast = 1'b0;
      s_wvalid = 1'b0;
      s_bready = 1'b1;
      m_awready = 1'b1;
      m_wready = 1'b1;
      m_bid = '0;
      m_bresp = RESP_OKAY;
      m_bvalid = 1'b0;
      cfg_cmd = MAP_NOP;
      cfg_index = '0;
      cfg_hppa = '0;
      cfg_ppa = '0;
      for (int i = 0; i < MAP_ENTRIES; i++) map_valid[i] = 1'b0;
      reset_state();
      translation_hit();
      miss_and_clear();
      bypass_inactive();
      pending_cap();
      repeat (2) step();
      $display("All tests passed!");
      $finish;
   end

endmodule

// File: design/hacd_wr_top.sv
/* AXI4 write-path page translation. Read channels are not handled and AW side
   fields other than id, addr, len, size and burst are not carried. */
`timescale 1ns/10ps

module hacd_wr_top #(
   parameter int ADDR_WIDTH  = 32,
   parameter int DATA_WIDTH  = 32,
   parameter int ID_WIDTH    = 4,
   parameter int MAP_ENTRIES = 8,
   parameter int MAX_PENDING = 4,
   localparam int PAGE_BITS  = ADDR_WIDTH - hawk_pkg::PAGE_OFFSET_BITS,
   localparam int STRB_WIDTH = DATA_WIDTH / 8,
   localparam int IDX_W      = (MAP_ENTRIES > 1) ? $clog2(MAP_ENTRIES) : 1
) (
   input  logic clk,
   input  logic rst,
   input  logic hawk_inactive,
   input  logic [ID_WIDTH-1:0] s_awid,
   input  logic [ADDR_WIDTH-1:0] s_awaddr,
   input  logic [axi_cfg_pkg::AXI_LEN_W-1:0] s_awlen,
   input  logic [axi_cfg_pkg::AXI_SIZE_W-1:0] s_awsize,
   input  axi_cfg_pkg::burst_t s_awburst,
   input  logic s_awvalid,
   output logic s_awready,
   input  logic [DATA_WIDTH-1:0] s_wdata,
   input  logic [STRB_WIDTH-1:0] s_wstrb,
   input  logic s_wlast,
   input  logic s_wvalid,
   output logic s_wready,
   output logic [ID_WIDTH-1:0] s_bid,
   output axi_cfg_pkg::resp_t s_bresp,
   output logic s_bvalid,
   input  logic s_bready,
   output logic [ID_WIDTH-1:0] m_awid,
   output logic [ADDR_WIDTH-1:0] m_awaddr,
   output logic [axi_cfg_pkg::AXI_LEN_W-1:0] m_awlen,
   output logic [axi_cfg_pkg::AXI_SIZE_W-1:0] m_awsize,
   output axi_cfg_pkg::burst_t m_awburst,
   output logic m_awvalid,
   input  logic m_awready,
   output logic [DATA_WIDTH-1:0] m_wdata,
   output logic [STRB_WIDTH-1:0] m_wstrb,
   output logic m_wlast,
   output logic m_wvalid,
   input  logic m_wready,
   input  logic [ID_WIDTH-1:0] m_bid,
   input  axi_cfg_pkg::resp_t m_bresp,
   input  logic m_bvalid,
   output logic m_bready,
   // Page map programming
   input  hawk_pkg::map_cmd_t cfg_cmd,
   input  logic [IDX_W-1:0] cfg_index,
   input  logic [PAGE_BITS-1:0] cfg_hppa,
   input  logic [PAGE_BITS-1:0] cfg_ppa
);

   logic lookup_req, grant, pending_full, aw_fire, b_fire;
   logic [PAGE_BITS-1:0] lookup_hppa, grant_ppa, tbl_lookup_hppa, tbl_ppa;

   // Memory-side handshakes drive the outstanding count
   assign aw_fire = m_awvalid && m_awready;
   assign b_fire  = m_bvalid && m_bready;

   hawk_cpu_stall_wr #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH),
      .ID_WIDTH(ID_WIDTH)) stall_wr_i (.*);

   pending_rsp_counter #(.MAX_PENDING(MAX_PENDING)) pending_i (.clk(clk),
      .rst(rst), .aw_fire(aw_fire), .b_fire(b_fire), .pending_full(pending_full));

   hawk_lookup_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) lookup_i (.clk(clk), .rst(rst),
      .lookup_req(lookup_req), .lookup_hppa(lookup_hppa), .grant(grant),
      .grant_ppa(grant_ppa), .tbl_lookup_hppa(tbl_lookup_hppa), .tbl_ppa(tbl_ppa));

   // Hit flag unused here, a miss grants the identity page
   page_map_table #(.ADDR_WIDTH(ADDR_WIDTH), .MAP_ENTRIES(MAP_ENTRIES)) table_i (
      .clk(clk), .rst(rst), .cfg_cmd(cfg_cmd), .cfg_index(cfg_index),
      .cfg_hppa(cfg_hppa), .cfg_ppa(cfg_ppa), .lookup_hppa(tbl_lookup_hppa),
      .hit(), .ppa(tbl_ppa));

endmodule

// File: hawk/hawk_lookup_ctrl.sv
/* Answers one stall request at a time, three cycles from request to grant.
   A table miss still grants, with the host page as the identity mapping. */
`timescale 1ns/10ps

module hawk_lookup_ctrl #(
   parameter int ADDR_WIDTH = 32,
   localparam int PAGE_BITS = ADDR_WIDTH - hawk_pkg::PAGE_OFFSET_BITS
) (
   input  logic                 clk,
   input  logic                 rst,
   // Stall side
   input  logic                 lookup_req,
   input  logic [PAGE_BITS-1:0] lookup_hppa,
   output logic                 grant,
   output logic [PAGE_BITS-1:0] grant_ppa,
   // Table side
   output logic [PAGE_BITS-1:0] tbl_lookup_hppa,
   input  logic [PAGE_BITS-1:0] tbl_ppa
);

   typedef enum logic [1:0] {
      LK_IDLE,
      LK_SEARCH,
      LK_GRANT
   } lk_state_t;

   lk_state_t state;

   // Table registers this on the same edge we leave LK_IDLE
   assign tbl_lookup_hppa = lookup_req ? lookup_hppa : '0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= LK_IDLE;
      end else begin
         case (state)
            LK_IDLE: begin
               if (lookup_req) begin
                  state <= LK_SEARCH;
               end
            end
            LK_SEARCH: state <= LK_GRANT;
            LK_GRANT:  state <= LK_IDLE;
            default:   state <= LK_IDLE;
         endcase
      end
   end

   // Registered table result is valid during SEARCH
   always_ff @(posedge clk) begin
      if (state == LK_SEARCH) begin
         grant_ppa <= tbl_ppa;
      end
   end

   // One-cycle pulse, stall side drops its request in the same cycle
   assign grant = (state == LK_GRANT);

   // Host page must not move while its lookup is in flight
   a_hppa_held: assert property (@(posedge clk) disable iff (rst)
      state == LK_SEARCH |-> $stable(lookup_hppa));

endmodule

// File: hawk/page_map_table.sv
/* Fully associative host-to-physical page map with a one-cycle registered
   lookup. A miss returns the host page unchanged; duplicate tags resolve to the lowest index. */
`timescale 1ns/10ps

module page_map_table #(
   parameter int ADDR_WIDTH  = 32,
   parameter int MAP_ENTRIES = 8,
   localparam int PAGE_BITS  = ADDR_WIDTH - hawk_pkg::PAGE_OFFSET_BITS,
   localparam int IDX_W      = (MAP_ENTRIES > 1) ? $clog2(MAP_ENTRIES) : 1
) (
   input  logic                 clk,
   input  logic                 rst,
   input  hawk_pkg::map_cmd_t   cfg_cmd,
   input  logic [IDX_W-1:0]     cfg_index,
   input  logic [PAGE_BITS-1:0] cfg_hppa,
   input  logic [PAGE_BITS-1:0] cfg_ppa,
   input  logic [PAGE_BITS-1:0] lookup_hppa,
   output logic                 hit,
   output logic [PAGE_BITS-1:0] ppa
);
   import hawk_pkg::*;

   logic [MAP_ENTRIES-1:0] valid;
   logic [PAGE_BITS-1:0]   tag  [MAP_ENTRIES];
   logic [PAGE_BITS-1:0]   phys [MAP_ENTRIES];
   logic                   match_hit;
   logic [PAGE_BITS-1:0]   match_ppa;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid <= '0;
         hit   <= 1'b0;
      end else begin
         hit <= match_hit;
         if (cfg_cmd == MAP_CLEAR) begin
            valid <= '0;
         end else if (cfg_cmd == MAP_WRITE) begin
            valid[cfg_index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_cmd == MAP_WRITE) begin
         tag[cfg_index]  <= cfg_hppa;
         phys[cfg_index] <= cfg_ppa;
      end
      ppa <= match_ppa;
   end

   // Scan downward so the lowest matching index wins
   always_comb begin
      match_hit = 1'b0;
      match_ppa = lookup_hppa;
      for (int i = MAP_ENTRIES - 1; i >= 0; i--) begin
         if (valid[i] && (tag[i] == lookup_hppa)) begin
            match_hit = 1'b1;
            match_ppa = phys[i];
         end
      end
   end

   a_index_range: assert property (@(posedge clk) disable iff (rst)
      cfg_cmd == MAP_WRITE |-> cfg_index < MAP_ENTRIES);

endmodule

// File: stall_wr/hawk_cpu_stall_wr.sv
/* Holds one AW request at a time until its page is translated. W and B are not
   tied to AW order and pass through with no latency. */
`timescale 1ns/10ps

module hawk_cpu_stall_wr #(
   parameter int ADDR_WIDTH  = 32,
   parameter int DATA_WIDTH  = 32,
   parameter int ID_WIDTH    = 4,
   localparam int PAGE_BITS  = ADDR_WIDTH - hawk_pkg::PAGE_OFFSET_BITS,
   localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
   input  logic                                 clk,
   input  logic                                 rst,
   // CPU side
   input  logic [ID_WIDTH-1:0]                  s_awid,
   input  logic [ADDR_WIDTH-1:0]                s_awaddr,
   input  logic [axi_cfg_pkg::AXI_LEN_W-1:0]    s_awlen,
   input  logic [axi_cfg_pkg::AXI_SIZE_W-1:0]   s_awsize,
   input  axi_cfg_pkg::burst_t                  s_awburst,
   input  logic                                 s_awvalid,
   output logic                                 s_awready,
   input  logic [DATA_WIDTH-1:0]                s_wdata,
   input  logic [STRB_WIDTH-1:0]                s_wstrb,
   input  logic                                 s_wlast,
   input  logic                                 s_wvalid,
   output logic                                 s_wready,
   output logic [ID_WIDTH-1:0]                  s_bid,
   output axi_cfg_pkg::resp_t                   s_bresp,
   output logic                                 s_bvalid,
   input  logic                                 s_bready,
   // Memory side
   output logic [ID_WIDTH-1:0]                  m_awid,
   output logic [ADDR_WIDTH-1:0]                m_awaddr,
   output logic [axi_cfg_pkg::AXI_LEN_W-1:0]    m_awlen,
   output logic [axi_cfg_pkg::AXI_SIZE_W-1:0]   m_awsize,
   output axi_cfg_pkg::burst_t                  m_awburst,
   output logic                                 m_awvalid,
   input  logic                                 m_awready,
   output logic [DATA_WIDTH-1:0]                m_wdata,
   output logic [STRB_WIDTH-1:0]                m_wstrb,
   output logic                                 m_wlast,
   output logic                                 m_wvalid,
   input  logic                                 m_wready,
   input  logic [ID_WIDTH-1:0]                  m_bid,
   input  axi_cfg_pkg::resp_t                   m_bresp,
   input  logic                                 m_bvalid,
   output logic                                 m_bready,
   // Translation side
   input  logic                                 hawk_inactive,
   input  logic                                 grant,
   input  logic [PAGE_BITS-1:0]                 grant_ppa,
   input  logic                                 pending_full,
   output logic                                 lookup_req,
   output logic [PAGE_BITS-1:0]                 lookup_hppa
);
   import axi_cfg_pkg::*;
   import hawk_pkg::*;

   typedef enum logic [1:0] {IDLE, WAIT, ISSUE} state_t;

   state_t                  state;
   logic                    s_awready_q;
   logic                    m_awvalid_q;
   logic                    allow_q;
   logic [ID_WIDTH-1:0]     awid_q;
   logic [ADDR_WIDTH-1:0]   awaddr_q;
   logic [AXI_LEN_W-1:0]    awlen_q;
   logic [AXI_SIZE_W-1:0]   awsize_q;
   burst_t                  awburst_q;
   logic                    s_aw_fire;
   logic                    m_aw_fire;
   logic                    go_issue;

   assign s_aw_fire = s_awvalid && s_awready_q;
   assign m_aw_fire = m_awvalid_q && m_awready;
   // Lookup answered on an earlier cycle, or translation bypassed
   assign go_issue  = (state == WAIT) && (allow_q || hawk_inactive);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= IDLE;
         s_awready_q <= 1'b0;
         m_awvalid_q <= 1'b0;
         allow_q     <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               s_awready_q <= !s_aw_fire;
               if (s_aw_fire) begin
                  state <= WAIT;
               end
            end
            WAIT: begin
               if (grant) begin
                  allow_q <= 1'b1;
               end
               if (go_issue) begin
                  state       <= ISSUE;
                  allow_q     <= 1'b0;
                  m_awvalid_q <= !pending_full;
               end
            end
            ISSUE: begin
               if (m_aw_fire) begin
                  state       <= IDLE;
                  m_awvalid_q <= 1'b0;
                  s_awready_q <= 1'b1;
               end else if (!pending_full) begin
                  m_awvalid_q <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Held request, page bits swapped once the grant lands
   always_ff @(posedge clk) begin
      if (s_aw_fire) begin
         awid_q    <= s_awid;
         awaddr_q  <= s_awaddr;
         awlen_q   <= s_awlen;
         awsize_q  <= s_awsize;
         awburst_q <= s_awburst;
      end else if ((state == WAIT) && grant && !allow_q) begin
         awaddr_q <= {grant_ppa, awaddr_q[PAGE_OFFSET_BITS-1:0]};
      end
   end

   // Drops in the grant cycle so one request never gets two answers
   assign lookup_req  = (state == WAIT) && !allow_q && !grant && !hawk_inactive;
   assign lookup_hppa = awaddr_q[ADDR_WIDTH-1:PAGE_OFFSET_BITS];

   assign s_awready = s_awready_q;
   assign m_awvalid = m_awvalid_q;
   assign m_awid    = awid_q;
   assign m_awaddr  = awaddr_q;
   assign m_awlen   = awlen_q;
   assign m_awsize  = awsize_q;
   assign m_awburst = awburst_q;

   // W and B straight through
   assign m_wdata  = s_wdata;
   assign m_wstrb  = s_wstrb;
   assign m_wlast  = s_wlast;
   assign m_wvalid = s_wvalid;
   assign s_wready = m_wready;
   assign s_bid    = m_bid;
   assign s_bresp  = m_bresp;
   assign s_bvalid = m_bvalid;
   assign m_bready = s_bready;

   a_awaddr_stable: assert property (@(posedge clk) disable iff (rst)
      m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr));

   // Controller only answers a request that is still waiting here
   a_grant_in_wait: assert property (@(posedge clk) disable iff (rst)
      grant |-> state == WAIT);

endmodule

// File: stall_wr/pending_rsp_counter.sv
/* Tracks forwarded writes still owed a B response. Assumes every forwarded AW
   gets exactly one B; pending_full blocks the next AW at MAX_PENDING. */
`timescale 1ns/10ps

module pending_rsp_counter #(
   parameter int MAX_PENDING = 4,
   localparam int CNT_W      = $clog2(MAX_PENDING + 1)
) (
   input  logic clk,
   input  logic rst,
   input  logic aw_fire,
   input  logic b_fire,
   output logic pending_full
);

   logic [CNT_W-1:0] count;

   // AW and B in the same cycle cancel out
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (aw_fire && !b_fire) begin
         count <= count + 1'b1;
      end else if (b_fire && !aw_fire) begin
         count <= count - 1'b1;
      end
   end

   assign pending_full = (count == CNT_W'(MAX_PENDING));

   // A B with nothing outstanding means the downstream ID bookkeeping broke
   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      b_fire && !aw_fire |-> count != '0);

   // Stall side must hold back its AW once the cap is reached
   a_no_inc_full: assert property (@(posedge clk) disable iff (rst)
      aw_fire |-> !pending_full);

endmodule

// File: common/hawk_pkg.sv
/* Page translation constants. Pages are a fixed 4 KB, so the low offset bits
   of an address always pass through and only the page number is remapped. */
package hawk_pkg;

   // 4 KB page offset
   localparam int PAGE_OFFSET_BITS = 12;

   // Page map programming commands
   // Sampled on every clock, so software holds MAP_NOP between commands
   typedef enum logic [1:0] {
      MAP_NOP   = 2'b00,
      // Load the entry at cfg_index and mark it valid
      MAP_WRITE = 2'b01,
      // Invalidate every entry at once
      MAP_CLEAR = 2'b10
   } map_cmd_t;

   // The remaining code 2'b11 is unused and behaves like MAP_NOP

   // A page number is ADDR_WIDTH - PAGE_OFFSET_BITS wide and is worked out
   // inside each module from its own ADDR_WIDTH

endpackage

// File: common/axi_cfg_pkg.sv
/* AXI4 write-path field widths and encodings. Lock, cache, prot, qos, region
   and user are not carried by this design, so nothing here describes them. */
package axi_cfg_pkg;

   // AWLEN and AWSIZE widths as fixed by AXI4
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_SIZE_W = 3;

   // AWBURST encoding
   // 2'b11 is reserved by the protocol and never issued
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } burst_t;

   // BRESP encoding
   // EXOKAY only follows an exclusive access, which this path never
   // generates on its own
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } resp_t;

   // Responses are passed through untouched, so the memory side decides
   // which of these reaches the CPU

endpackage
